//--- src/lsu_defs.svh
// width and depth parameters for the load/store unit
// the RAM depth must be a power of two, upper address bits wrap

`ifndef LSU_DEFS_SVH
`define LSU_DEFS_SVH

// data and address width in bits
// byte lanes are derived from this, so keep it a multiple of 8
`define LSU_XLEN 32

// data RAM depth in words of LSU_XLEN bits
// addresses above the RAM size alias back onto it
`define LSU_DMEM_WORDS 256

`endif

//--- src/lsu_pkg.sv
// shared types of the load/store unit
// the opcode encoding follows the decoder, so bit 3 marks a store

`include "lsu_defs.svh"

package lsu_pkg;

    // memory operation coming from execute
    typedef enum logic [3:0] {
        mem_none = 4'd0,
        mem_lb   = 4'd1,
        mem_lh   = 4'd2,
        mem_lw   = 4'd3,
        mem_lbu  = 4'd4,
        mem_lhu  = 4'd5,
        mem_sw   = 4'd8,
        mem_sb   = 4'd14,
        mem_sh   = 4'd15
    } mem_op_e;

    // one write enable per byte lane, lane 0 is the low byte
    typedef logic [`LSU_XLEN/8-1:0] byte_en_t;

endpackage

//--- src/mem_req_if.sv
// registered request from the address stage to the RAM and the load aligner
// all signals are single-cycle levels, there is no handshake

`include "lsu_defs.svh"

interface mem_req_if;

    // write and read strobes, both already cleared on misalignment
    logic                  we;
    logic                  rd;
    lsu_pkg::byte_en_t     be;

    // full byte address and lane-replicated store data
    logic [`LSU_XLEN-1:0]  addr;
    logic [`LSU_XLEN-1:0]  wdata;

    // operation, needed again by the aligner for the extension
    lsu_pkg::mem_op_e      op;

    modport gen (
        output we,
        output rd,
        output be,
        output addr,
        output wdata,
        output op
    );

    modport mem (
        input we,
        input be,
        input addr,
        input wdata
    );

    // rd lets the aligner suppress data for misaligned loads
    modport align (
        input op,
        input addr,
        input rd
    );

endinterface

//--- src/mem_addr_gen.sv
// address stage of the LSU, two register stages from input to RAM request
// misaligned accesses raise the flag and never touch memory
// opcodes outside the enum decode as no operation

`include "lsu_defs.svh"

module mem_addr_gen (
    input  logic                  clk,
    input  logic                  nrst,
    input  lsu_pkg::mem_op_e      i_mem_op,
    input  logic [`LSU_XLEN-1:0]  i_base,
    input  logic [`LSU_XLEN-1:0]  i_src_imm,
    input  logic [`LSU_XLEN-1:0]  i_s_imm,
    output logic                  o_addr_misaligned,
    mem_req_if.gen                req
);

    // stage 5 registers
    lsu_pkg::mem_op_e      op_s5;
    logic [`LSU_XLEN-1:0]  base_s5;
    logic [`LSU_XLEN-1:0]  src_imm_s5;
    logic [`LSU_XLEN-1:0]  s_imm_s5;

    // stage 5 decode and request
    logic                  is_load;
    logic                  is_byte;
    logic                  is_half;
    logic                  is_word;
    logic [`LSU_XLEN-1:0]  addr_s5;
    logic                  misaligned_s5;
    lsu_pkg::byte_en_t     be_s5;
    logic [`LSU_XLEN-1:0]  wdata_s5;
    logic                  we_s5;
    logic                  rd_s5;

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            op_s5 <= lsu_pkg::mem_none;
        end else begin
            op_s5 <= i_mem_op;
        end
    end

    // operands only matter when op_s5 is a real access
    always_ff @(posedge clk) begin
        base_s5    <= i_base;
        src_imm_s5 <= i_src_imm;
        s_imm_s5   <= i_s_imm;
    end

    // access size and direction
    always_comb begin
        is_load = 1'b0;
        is_byte = 1'b0;
        is_half = 1'b0;
        is_word = 1'b0;
        case (op_s5)
            lsu_pkg::mem_lb, lsu_pkg::mem_lbu: begin
                is_load = 1'b1;
                is_byte = 1'b1;
            end
            lsu_pkg::mem_lh, lsu_pkg::mem_lhu: begin
                is_load = 1'b1;
                is_half = 1'b1;
            end
            lsu_pkg::mem_lw: begin
                is_load = 1'b1;
                is_word = 1'b1;
            end
            lsu_pkg::mem_sb: is_byte = 1'b1;
            lsu_pkg::mem_sh: is_half = 1'b1;
            lsu_pkg::mem_sw: is_word = 1'b1;
            default: ;
        endcase
    end

    // stores offset by the S-immediate, loads by the I-immediate
    assign addr_s5 = base_s5 + (op_s5[3] ? s_imm_s5 : src_imm_s5);

    assign misaligned_s5 = (is_half & addr_s5[0])
                         | (is_word & (addr_s5[1] | addr_s5[0]));

    // lane enables and replicated store data
    always_comb begin
        be_s5    = '0;
        wdata_s5 = src_imm_s5;
        if (is_byte && !is_load) begin
            be_s5    = lsu_pkg::byte_en_t'(1) << addr_s5[1:0];
            wdata_s5 = {4{src_imm_s5[7:0]}};
        end else if (is_half && !is_load) begin
            be_s5    = addr_s5[1] ? 4'b1100 : 4'b0011;
            wdata_s5 = {2{src_imm_s5[15:0]}};
        end else if (is_word && !is_load) begin
            be_s5    = 4'b1111;
        end
        if (misaligned_s5) begin
            be_s5 = '0;
        end
    end

    assign we_s5 = (is_byte | is_half | is_word) & ~is_load & ~misaligned_s5;
    assign rd_s5 = is_load & ~misaligned_s5;

    // stage 6 control
    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            req.we            <= 1'b0;
            req.rd            <= 1'b0;
            req.be            <= '0;
            req.op            <= lsu_pkg::mem_none;
            o_addr_misaligned <= 1'b0;
        end else begin
            req.we            <= we_s5;
            req.rd            <= rd_s5;
            req.be            <= be_s5;
            req.op            <= op_s5;
            o_addr_misaligned <= misaligned_s5;
        end
    end

    // stage 6 payload
    always_ff @(posedge clk) begin
        req.addr  <= addr_s5;
        req.wdata <= wdata_s5;
    end

endmodule

//--- src/data_mem.sv
// byte-writable data RAM, clocked write and combinational read
// contents are undefined until written, addresses wrap at the RAM size

`include "lsu_defs.svh"

module data_mem (
    input  logic                  clk,
    mem_req_if.mem                mem,
    output logic [`LSU_XLEN-1:0]  o_rdata
);

    localparam int LANES   = `LSU_XLEN / 8;
    localparam int DEPTH   = `LSU_DMEM_WORDS;
    localparam int IDX_W   = $clog2(DEPTH);
    localparam int LANE_W  = $clog2(LANES);

    logic [`LSU_XLEN-1:0]  mem_words [DEPTH];
    logic [IDX_W-1:0]      word_idx;

    // word index sits just above the byte offset
    assign word_idx = mem.addr[IDX_W+LANE_W-1:LANE_W];

    // each enabled lane written on its own
    always_ff @(posedge clk) begin
        if (mem.we) begin
            for (int lane = 0; lane < LANES; lane++) begin
                if (mem.be[lane]) begin
                    mem_words[word_idx][8*lane +: 8] <= mem.wdata[8*lane +: 8];
                end
            end
        end
    end

    // read port sees the current word, a store lands at the next edge
    assign o_rdata = mem_words[word_idx];

endmodule

//--- src/load_align.sv
// picks the addressed byte or halfword out of the RAM word and extends it
// output is 0 unless a valid, aligned load is in stage 6

`include "lsu_defs.svh"

module load_align (
    mem_req_if.align              req,
    input  logic [`LSU_XLEN-1:0]  i_rdata,
    output logic [`LSU_XLEN-1:0]  o_load_data
);

    logic [7:0]   sel_byte;
    logic [15:0]  sel_half;

    // lane chosen by the low address bits
    assign sel_byte = i_rdata[8*req.addr[1:0] +: 8];
    assign sel_half = i_rdata[16*req.addr[1] +: 16];

    always_comb begin
        o_load_data = '0;
        if (req.rd) begin
            case (req.op)
                lsu_pkg::mem_lb:  o_load_data = {{(`LSU_XLEN-8){sel_byte[7]}}, sel_byte};
                lsu_pkg::mem_lbu: o_load_data = {{(`LSU_XLEN-8){1'b0}}, sel_byte};
                lsu_pkg::mem_lh:  o_load_data = {{(`LSU_XLEN-16){sel_half[15]}}, sel_half};
                lsu_pkg::mem_lhu: o_load_data = {{(`LSU_XLEN-16){1'b0}}, sel_half};
                lsu_pkg::mem_lw:  o_load_data = i_rdata;
                // stores and none return nothing
                default:          o_load_data = '0;
            endcase
        end
    end

endmodule

//--- src/lsu_top.sv
// memory stage top, fixed two-cycle latency from issue to load data
// one operation per clock, no stall, misaligned flag is the only exception

`include "lsu_defs.svh"

module lsu_top (
    input  logic                  clk,
    input  logic                  nrst,
    input  logic [3:0]            i_mem_op,
    input  logic [`LSU_XLEN-1:0]  i_base,
    input  logic [`LSU_XLEN-1:0]  i_src_imm,
    input  logic [`LSU_XLEN-1:0]  i_s_imm,
    output logic [`LSU_XLEN-1:0]  o_load_data,
    output logic                  o_addr_misaligned
);

    // stage 6 request shared by RAM and aligner
    mem_req_if req_bus ();

    logic [`LSU_XLEN-1:0] rdata;

    mem_addr_gen u_addr_gen (
        .clk               (clk),
        .nrst              (nrst),
        .i_mem_op          (lsu_pkg::mem_op_e'(i_mem_op)),
        .i_base            (i_base),
        .i_src_imm         (i_src_imm),
        .i_s_imm           (i_s_imm),
        .o_addr_misaligned (o_addr_misaligned),
        .req               (req_bus.gen)
    );

    data_mem u_dmem (
        .clk     (clk),
        .mem     (req_bus.mem),
        .o_rdata (rdata)
    );

    load_align u_align (
        .req         (req_bus.align),
        .i_rdata     (rdata),
        .o_load_data (o_load_data)
    );

endmodule

//--- verif/lsu_tb.sv
// self-checking testbench for the LSU memory stage
// the whole RAM is written first so that no later load reads an unwritten word
// expected results come from a byte-wide shadow RAM and are checked two cycles after issue

`include "lsu_defs.svh"

module lsu_tb;

    localparam int BYTES     = `LSU_DMEM_WORDS * 4;
    localparam int N_RAW     = 40;
    localparam int N_LANE    = 24;
    localparam int N_EXT     = 24;
    localparam int N_MIS     = 16;
    localparam int N_ADDR    = 16;
    // idle ops before and after plus the op count of each phase below
    localparam int TOTAL_OPS = 8 + `LSU_DMEM_WORDS + 2 * N_RAW + 12 * N_LANE
                             + 13 * N_EXT + 6 * N_MIS + 2 * N_ADDR;
    localparam int TIMEOUT_CYCLES = 2 * TOTAL_OPS + 50;

    typedef struct packed {
        logic [31:0] key;
        logic [3:0]  op;
        logic [31:0] data;
        logic        mis;
    } exp_entry_t;

    logic                  clk;
    logic                  nrst;
    logic [3:0]            i_mem_op;
    logic [`LSU_XLEN-1:0]  i_base;
    logic [`LSU_XLEN-1:0]  i_src_imm;
    logic [`LSU_XLEN-1:0]  i_s_imm;
    logic [`LSU_XLEN-1:0]  o_load_data;
    logic                  o_addr_misaligned;

    // shadow RAM with one entry per byte and lane 0 at the lowest address
    logic [7:0]   shadow [BYTES];
    exp_entry_t   exp_q [$];
    exp_entry_t   head;
    logic [31:0]  cyc = 32'd0;
    logic [31:0]  rng_state = 32'd35049;

    // expectation for the cycle being checked
    logic         chk_valid = 1'b0;
    logic [3:0]   chk_op;
    logic [31:0]  chk_data;
    logic         chk_mis;

    lsu_top lsu_inst (
        .clk               (clk),
        .nrst              (nrst),
        .i_mem_op          (i_mem_op),
        .i_base            (i_base),
        .i_src_imm         (i_src_imm),
        .i_s_imm           (i_s_imm),
        .o_load_data       (o_load_data),
        .o_addr_misaligned (o_addr_misaligned)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic logic [31:0] next_rand();
        rng_state = rng_state * 32'd1664525 + 32'd1013904223;
        return rng_state ^ (rng_state >> 16);
    endfunction

    // 12-bit signed immediate of either sign
    function automatic logic [31:0] rand_imm();
        logic [31:0] r;
        r = next_rand();
        return {{20{r[31]}}, r[31:20]};
    endfunction

    // one op per call driven just after the rising edge
    task automatic issue_op(input lsu_pkg::mem_op_e op, input logic [31:0] addr,
                            input logic [31:0] imm, input logic [31:0] data);
        int unsigned nbytes;
        int unsigned idx;
        logic        is_store;
        logic        mis;
        exp_entry_t  ent;
        case (op)
            lsu_pkg::mem_lb, lsu_pkg::mem_lbu, lsu_pkg::mem_sb: nbytes = 1;
            lsu_pkg::mem_lh, lsu_pkg::mem_lhu, lsu_pkg::mem_sh: nbytes = 2;
            lsu_pkg::mem_lw, lsu_pkg::mem_sw: nbytes = 4;
            default: nbytes = 0;
        endcase
        is_store = op[3];
        mis = (nbytes == 2 && addr[0]) || (nbytes == 4 && addr[1:0] != 2'b00);
        idx = addr & (BYTES - 1);
        ent.op = op;
        ent.mis = mis;
        ent.data = '0;
        if (is_store && !mis) begin
            for (int i = 0; i < nbytes; i++) begin
                shadow[idx + i] = data[8*i +: 8];
            end
        end else if (!mis) begin
            case (op)
                lsu_pkg::mem_lb:  ent.data = {{24{shadow[idx][7]}}, shadow[idx]};
                lsu_pkg::mem_lbu: ent.data = {24'd0, shadow[idx]};
                lsu_pkg::mem_lh:  ent.data = {{16{shadow[idx + 1][7]}}, shadow[idx + 1], shadow[idx]};
                lsu_pkg::mem_lhu: ent.data = {16'd0, shadow[idx + 1], shadow[idx]};
                lsu_pkg::mem_lw:  ent.data = {shadow[idx + 3], shadow[idx + 2],
                                              shadow[idx + 1], shadow[idx]};
                default:          ent.data = '0;
            endcase
        end
        @(posedge clk);
        #2;
        i_mem_op = op;
        i_base   = addr - imm;
        // the unused immediate gets noise that must not affect the address
        if (is_store) begin
            i_s_imm   = imm;
            i_src_imm = data;
        end else begin
            i_src_imm = imm;
            i_s_imm   = next_rand();
        end
        ent.key = cyc + 32'd2;
        exp_q.push_back(ent);
    endtask

    always @(posedge clk) begin
        if (cyc >= TIMEOUT_CYCLES) begin
            $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("STATUS: FAIL");
            $fatal(1);
        end else begin
            cyc <= cyc + 32'd1;
        end
    end

    // load the result due in this cycle for the check at the next rising edge
    always @(negedge clk) begin
        if (exp_q.size() > 0 && exp_q[0].key == cyc) begin
            head      = exp_q.pop_front();
            chk_valid = 1'b1;
            chk_op    = head.op;
            chk_data  = head.data;
            chk_mis   = head.mis;
        end else begin
            chk_valid = 1'b0;
        end
    end

    load_data_check: assert property (@(posedge clk) disable iff (!nrst)
        !chk_valid || (o_load_data == chk_data))
    else begin
        $display("error at %0t: op %h returned load data %h, expected %h",
                 $time, $sampled(chk_op), $sampled(o_load_data), $sampled(chk_data));
        $display("STATUS: FAIL");
        $fatal(1);
    end

    misaligned_check: assert property (@(posedge clk) disable iff (!nrst)
        !chk_valid || (o_addr_misaligned == chk_mis))
    else begin
        $display("error at %0t: op %h gave misaligned flag %b, expected %b",
                 $time, $sampled(chk_op), $sampled(o_addr_misaligned), $sampled(chk_mis));
        $display("STATUS: FAIL");
        $fatal(1);
    end

    initial begin : stimulus
        logic [31:0] wa;
        logic [31:0] r;
        logic [31:0] odd;
        logic [31:0] nz;
        logic [31:0] neg_imm;
        logic [31:0] pos_imm;
        exp_entry_t  idle_ent;
        i_mem_op  = 4'd0;
        i_base    = '0;
        i_src_imm = '0;
        i_s_imm   = '0;
        nrst      = 1'b0;
        repeat (4) @(posedge clk);
        #2;
        nrst = 1'b1;

        // reset values stay on the outputs until the first op reaches stage 6
        idle_ent.op   = 4'd0;
        idle_ent.data = '0;
        idle_ent.mis  = 1'b0;
        for (int c = 0; c < 3; c++) begin
            idle_ent.key = cyc + c;
            exp_q.push_back(idle_ent);
        end

        // idle ops after reset keep both outputs at 0
        repeat (4) issue_op(lsu_pkg::mem_none, next_rand(), next_rand(), next_rand());

        // fill every word while random upper address bits alias onto the RAM
        for (int w = 0; w < `LSU_DMEM_WORDS; w++) begin
            wa = (next_rand() & ~(BYTES - 1)) | (w * 4);
            issue_op(lsu_pkg::mem_sw, wa, rand_imm(), next_rand());
        end

        // word round trip with each load right behind its store
        for (int n = 0; n < N_RAW; n++) begin
            wa = next_rand() & ~32'd3;
            issue_op(lsu_pkg::mem_sw, wa, rand_imm(), next_rand());
            issue_op(lsu_pkg::mem_lw, wa, rand_imm(), '0);
        end

        // byte and halfword stores on every lane
        for (int n = 0; n < N_LANE; n++) begin
            wa = next_rand() & ~32'd3;
            for (int b = 0; b < 4; b++) begin
                issue_op(lsu_pkg::mem_sb, wa + b, rand_imm(), next_rand());
                issue_op(lsu_pkg::mem_lw, wa, rand_imm(), '0);
            end
            for (int h = 0; h < 2; h++) begin
                issue_op(lsu_pkg::mem_sh, wa + 2 * h, rand_imm(), next_rand());
                issue_op(lsu_pkg::mem_lw, wa, rand_imm(), '0);
            end
        end

        // sign and zero extension with sign bits alternately all set and all clear
        for (int n = 0; n < N_EXT; n++) begin
            wa = next_rand() & ~32'd3;
            r = next_rand();
            r = (n % 2 == 1) ? (r | 32'h8080_8080) : (r & 32'h7f7f_7f7f);
            issue_op(lsu_pkg::mem_sw, wa, rand_imm(), r);
            for (int b = 0; b < 4; b++) begin
                issue_op(lsu_pkg::mem_lb, wa + b, rand_imm(), '0);
                issue_op(lsu_pkg::mem_lbu, wa + b, rand_imm(), '0);
            end
            for (int h = 0; h < 2; h++) begin
                issue_op(lsu_pkg::mem_lh, wa + 2 * h, rand_imm(), '0);
                issue_op(lsu_pkg::mem_lhu, wa + 2 * h, rand_imm(), '0);
            end
        end

        // misaligned accesses and then a word load to show memory untouched
        for (int n = 0; n < N_MIS; n++) begin
            wa = next_rand() & ~32'd3;
            r = next_rand();
            odd = {30'd0, r[31], 1'b1};
            nz = (r[29:28] == 2'd0) ? 32'd1 : {30'd0, r[29:28]};
            issue_op(lsu_pkg::mem_lh, wa + odd, rand_imm(), '0);
            issue_op(lsu_pkg::mem_lhu, wa + odd, rand_imm(), '0);
            issue_op(lsu_pkg::mem_sh, wa + odd, rand_imm(), next_rand());
            issue_op(lsu_pkg::mem_lw, wa + nz, rand_imm(), '0);
            issue_op(lsu_pkg::mem_sw, wa + nz, rand_imm(), next_rand());
            issue_op(lsu_pkg::mem_lw, wa, rand_imm(), '0);
        end

        // store and load through different base and immediate pairs
        for (int n = 0; n < N_ADDR; n++) begin
            wa = next_rand() & ~32'd3;
            neg_imm = rand_imm() | 32'hffff_f800;
            pos_imm = rand_imm() & 32'h0000_07ff;
            if (n % 2 == 0) begin
                issue_op(lsu_pkg::mem_sw, wa, neg_imm, next_rand());
                issue_op(lsu_pkg::mem_lw, wa, pos_imm, '0);
            end else begin
                issue_op(lsu_pkg::mem_sw, wa, pos_imm, next_rand());
                issue_op(lsu_pkg::mem_lw, wa, neg_imm, '0);
            end
        end

        // drain the pipeline
        repeat (4) issue_op(lsu_pkg::mem_none, '0, '0, '0);
        while (exp_q.size() != 0) begin
            @(posedge clk);
        end
        repeat (2) @(posedge clk);
        $display("STATUS: PASS");
        $finish;
    end

endmodule

//--- lsu.f
+incdir+src
src/lsu_pkg.sv
src/mem_req_if.sv
src/mem_addr_gen.sv
src/data_mem.sv
src/load_align.sv
src/lsu_top.sv
verif/lsu_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# builds the LSU testbench with Verilator and runs it
# the run passes only when the pass line appears in the simulation output

cd "$(dirname "$0")" || exit 1

verilator --binary --assert -Wno-fatal -j 0 \
    -f lsu.f \
    --top-module lsu_tb \
    --Mdir obj_dir \
    && ./obj_dir/Vlsu_tb 2>&1 | tee /dev/stderr | grep -x "STATUS: PASS" > /dev/null \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
